//--- design/dispatch_pkg.sv
// dispatch_pkg: ROB and dispatch sizes, operation class enum, functional unit enum
`default_nettype none

package dispatch_pkg;

	// ============================================================
	// sizes
	// ============================================================

	// reorder buffer depth and index width
	localparam int ROB_ENTRIES = 8;
	localparam int ROB_IDX_W   = 3;

	// dispatch slots per cycle
	localparam int DISP_WIDTH  = 2;

	// alu0, alu1, mul, mem, br
	localparam int NUM_FU      = 5;

	// ============================================================
	// encodings
	// ============================================================

	// operation class, picks which unit group an entry may use
	typedef enum logic [1:0] {
		OPC_ALU = 2'd0,
		OPC_MUL = 2'd1,
		OPC_MEM = 2'd2,
		OPC_BR  = 2'd3
	} op_class_e;

	// functional unit number, also the bit position in busy and done vectors
	typedef enum logic [2:0] {
		FU_ALU0 = 3'd0,
		FU_ALU1 = 3'd1,
		FU_MUL  = 3'd2,
		FU_MEM  = 3'd3,
		FU_BR   = 3'd4
	} fu_id_e;

endpackage

`default_nettype wire

//--- design/rob_table.sv
// rob_table: ROB entry state, lowest-free allocation, wakeup, out marking, completion
`timescale 1ns/1ps
`default_nettype none

module rob_table (
	input  wire                                                         clk,
	input  wire                                                         arst_n_i,
	input  wire                                                         alloc_v_i,
	input  wire dispatch_pkg::op_class_e                                alloc_class_i,
	input  wire [1:0]                                                   alloc_src_rdy_i,
	input  wire                                                         wake_v_i,
	input  wire [dispatch_pkg::ROB_IDX_W-1:0]                           wake_idx_i,
	input  wire                                                         wake_src_i,
	input  wire [dispatch_pkg::DISP_WIDTH-1:0]                          disp_v_i,
	input  wire [dispatch_pkg::ROB_IDX_W-1:0]                           disp_idx0_i,
	input  wire [dispatch_pkg::ROB_IDX_W-1:0]                           disp_idx1_i,
	input  wire [dispatch_pkg::ROB_ENTRIES-1:0]                         cpl_vec_i,
	output logic [dispatch_pkg::ROB_IDX_W-1:0]                          alloc_idx_o,
	output logic                                                        rob_full_o,
	output logic [dispatch_pkg::ROB_ENTRIES-1:0]                        entry_v_o,
	output logic [dispatch_pkg::ROB_ENTRIES-1:0]                        entry_out_o,
	output logic [dispatch_pkg::ROB_ENTRIES-1:0][1:0]                   entry_src_rdy_o,
	output dispatch_pkg::op_class_e [dispatch_pkg::ROB_ENTRIES-1:0]     entry_class_o
);

	logic [dispatch_pkg::ROB_ENTRIES-1:0] out_q;
	logic [dispatch_pkg::ROB_ENTRIES-1:0] mark_vec;
	logic                                 alloc_go;

	// ============================================================
	// allocation pointer
	// ============================================================

	// lowest invalid index wins, scan from the top so index 0 is written last
	always_comb begin
		alloc_idx_o = '0;
		for (int i = dispatch_pkg::ROB_ENTRIES - 1; i >= 0; i--) begin
			if (!entry_v_o[i])
				alloc_idx_o = dispatch_pkg::ROB_IDX_W'(i);
		end
	end

	assign rob_full_o = &entry_v_o;
	assign alloc_go   = alloc_v_i && !rob_full_o;

	// ============================================================
	// out marking
	// ============================================================

	// registered dispatch slots, one-hot per entry
	always_comb begin
		for (int i = 0; i < dispatch_pkg::ROB_ENTRIES; i++) begin
			mark_vec[i] = (disp_v_i[0] && disp_idx0_i == dispatch_pkg::ROB_IDX_W'(i)) ||
				(disp_v_i[1] && disp_idx1_i == dispatch_pkg::ROB_IDX_W'(i));
		end
	end

	// the slot register already holds this cycle's dispatches,
	// so the entry counts as out from the dispatch edge itself
	assign entry_out_o = out_q | mark_vec;

	// ============================================================
	// entry state
	// ============================================================

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			entry_v_o       <= '0;
			out_q           <= '0;
			entry_src_rdy_o <= '0;
		end else begin
			for (int i = 0; i < dispatch_pkg::ROB_ENTRIES; i++) begin
				if (alloc_go && alloc_idx_o == dispatch_pkg::ROB_IDX_W'(i)) begin
					// fresh entry, never sent
					entry_v_o[i]       <= 1'b1;
					out_q[i]           <= 1'b0;
					entry_src_rdy_o[i] <= alloc_src_rdy_i;
				end else begin
					// completing entry is still valid here, so alloc cannot collide
					if (cpl_vec_i[i])
						entry_v_o[i] <= 1'b0;
					if (mark_vec[i])
						out_q[i] <= 1'b1;
					// wakeup only touches live entries
					if (wake_v_i && entry_v_o[i] && wake_idx_i == dispatch_pkg::ROB_IDX_W'(i))
						entry_src_rdy_o[i][wake_src_i] <= 1'b1;
				end
			end
		end
	end

	// class is payload, written on allocation only
	always_ff @(posedge clk) begin
		if (alloc_go)
			entry_class_o[alloc_idx_o] <= alloc_class_i;
	end

endmodule

`default_nettype wire

//--- design/entry_ready_scan.sv
// entry_ready_scan: per-entry dispatch candidates and per-class request vectors
`timescale 1ns/1ps
`default_nettype none

module entry_ready_scan (
	input  wire [dispatch_pkg::ROB_ENTRIES-1:0]                     entry_v_i,
	input  wire [dispatch_pkg::ROB_ENTRIES-1:0]                     entry_out_i,
	input  wire [dispatch_pkg::ROB_ENTRIES-1:0][1:0]                entry_src_rdy_i,
	input  wire dispatch_pkg::op_class_e [dispatch_pkg::ROB_ENTRIES-1:0] entry_class_i,
	output logic [dispatch_pkg::ROB_ENTRIES-1:0]                    cand_vec_o,
	output logic [dispatch_pkg::ROB_ENTRIES-1:0]                    alu_req_o,
	output logic [dispatch_pkg::ROB_ENTRIES-1:0]                    mul_req_o,
	output logic [dispatch_pkg::ROB_ENTRIES-1:0]                    mem_req_o,
	output logic [dispatch_pkg::ROB_ENTRIES-1:0]                    br_req_o
);

	// ============================================================
	// candidate scan
	// ============================================================

	always_comb begin
		for (int i = 0; i < dispatch_pkg::ROB_ENTRIES; i++) begin
			// valid, still waiting to go out, both operands present
			cand_vec_o[i] = entry_v_i[i] && !entry_out_i[i] && (&entry_src_rdy_i[i]);

			// class split, selector only looks at these
			alu_req_o[i] = cand_vec_o[i] && (entry_class_i[i] == dispatch_pkg::OPC_ALU);
			mul_req_o[i] = cand_vec_o[i] && (entry_class_i[i] == dispatch_pkg::OPC_MUL);
			mem_req_o[i] = cand_vec_o[i] && (entry_class_i[i] == dispatch_pkg::OPC_MEM);
			br_req_o[i]  = cand_vec_o[i] && (entry_class_i[i] == dispatch_pkg::OPC_BR);
		end
	end

endmodule

`default_nettype wire

//--- design/fu_tracker.sv
// fu_tracker: per-unit busy bits, held ROB indices, done-to-completion mapping
`timescale 1ns/1ps
`default_nettype none

module fu_tracker (
	input  wire                                         clk,
	input  wire                                         arst_n_i,
	input  wire [dispatch_pkg::DISP_WIDTH-1:0]          disp_v_i,
	input  wire [dispatch_pkg::ROB_IDX_W-1:0]           disp_idx0_i,
	input  wire [dispatch_pkg::ROB_IDX_W-1:0]           disp_idx1_i,
	input  wire dispatch_pkg::fu_id_e                   disp_fu0_i,
	input  wire dispatch_pkg::fu_id_e                   disp_fu1_i,
	input  wire [dispatch_pkg::NUM_FU-1:0]              fu_done_i,
	output logic [dispatch_pkg::NUM_FU-1:0]             fu_busy_o,
	output logic [dispatch_pkg::ROB_ENTRIES-1:0]        cpl_vec_o
);

	logic [dispatch_pkg::NUM_FU-1:0]                         busy_q;
	logic [dispatch_pkg::NUM_FU-1:0][dispatch_pkg::ROB_IDX_W-1:0] held_q;
	logic [dispatch_pkg::NUM_FU-1:0][dispatch_pkg::ROB_IDX_W-1:0] held_idx;
	logic [dispatch_pkg::NUM_FU-1:0]                         claim0;
	logic [dispatch_pkg::NUM_FU-1:0]                         claim1;

	// ============================================================
	// per-unit claim and hold
	// ============================================================

	for (genvar g = 0; g < dispatch_pkg::NUM_FU; g++) begin : g_fu
		// slot register names this unit
		assign claim0[g] = disp_v_i[0] && (disp_fu0_i == dispatch_pkg::fu_id_e'(g));
		assign claim1[g] = disp_v_i[1] && (disp_fu1_i == dispatch_pkg::fu_id_e'(g));

		// a live slot is the newest owner, else the stored one
		assign held_idx[g] = claim0[g] ? disp_idx0_i :
			claim1[g] ? disp_idx1_i : held_q[g];

		// busy from the dispatch edge on
		assign fu_busy_o[g] = busy_q[g] | claim0[g] | claim1[g];
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy_q <= '0;
		end else begin
			// done wins, a unit is never claimed while busy
			busy_q <= (busy_q | claim0 | claim1) & ~fu_done_i;
		end
	end

	// held index is payload
	always_ff @(posedge clk) begin
		held_q <= held_idx;
	end

	// ============================================================
	// completion mask
	// ============================================================

	always_comb begin
		cpl_vec_o = '0;
		for (int f = 0; f < dispatch_pkg::NUM_FU; f++) begin
			if (fu_done_i[f])
				cpl_vec_o[held_idx[f]] = 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- design/dispatch_select.sv
// dispatch_select: two-slot in-order pick against free units, registered dispatch slots
`timescale 1ns/1ps
`default_nettype none

module dispatch_select (
	input  wire                                     clk,
	input  wire                                     arst_n_i,
	input  wire [dispatch_pkg::ROB_ENTRIES-1:0]     alu_req_i,
	input  wire [dispatch_pkg::ROB_ENTRIES-1:0]     mul_req_i,
	input  wire [dispatch_pkg::ROB_ENTRIES-1:0]     mem_req_i,
	input  wire [dispatch_pkg::ROB_ENTRIES-1:0]     br_req_i,
	input  wire [dispatch_pkg::ROB_ENTRIES-1:0]     cand_vec_i,
	input  wire [dispatch_pkg::NUM_FU-1:0]          fu_busy_i,
	output logic [dispatch_pkg::DISP_WIDTH-1:0]     disp_v_o,
	output logic [dispatch_pkg::ROB_IDX_W-1:0]      disp_idx0_o,
	output logic [dispatch_pkg::ROB_IDX_W-1:0]      disp_idx1_o,
	output dispatch_pkg::fu_id_e                    disp_fu0_o,
	output dispatch_pkg::fu_id_e                    disp_fu1_o
);

	// next-state picks
	logic [dispatch_pkg::DISP_WIDTH-1:0]  pick_v;
	logic [dispatch_pkg::ROB_IDX_W-1:0]   pick_idx0;
	logic [dispatch_pkg::ROB_IDX_W-1:0]   pick_idx1;
	dispatch_pkg::fu_id_e                 pick_fu0;
	dispatch_pkg::fu_id_e                 pick_fu1;

	// scan working state
	logic [dispatch_pkg::NUM_FU-1:0]      avail;
	logic                                 hit;
	dispatch_pkg::fu_id_e                 hit_fu;

	// ============================================================
	// in-order scan
	// ============================================================

	always_comb begin
		pick_v    = '0;
		pick_idx0 = '0;
		pick_idx1 = '0;
		pick_fu0  = dispatch_pkg::FU_ALU0;
		pick_fu1  = dispatch_pkg::FU_ALU0;
		// units free this cycle, cleared as they get granted
		avail     = ~fu_busy_i;
		hit       = 1'b0;
		hit_fu    = dispatch_pkg::FU_ALU0;

		for (int i = 0; i < dispatch_pkg::ROB_ENTRIES; i++) begin
			hit    = 1'b0;
			hit_fu = dispatch_pkg::FU_ALU0;

			// class decides the unit, alu0 preferred over alu1
			if (alu_req_i[i]) begin
				if (avail[dispatch_pkg::FU_ALU0]) begin
					hit    = 1'b1;
					hit_fu = dispatch_pkg::FU_ALU0;
				end else if (avail[dispatch_pkg::FU_ALU1]) begin
					hit    = 1'b1;
					hit_fu = dispatch_pkg::FU_ALU1;
				end
			end else if (mul_req_i[i] && avail[dispatch_pkg::FU_MUL]) begin
				hit    = 1'b1;
				hit_fu = dispatch_pkg::FU_MUL;
			end else if (mem_req_i[i] && avail[dispatch_pkg::FU_MEM]) begin
				hit    = 1'b1;
				hit_fu = dispatch_pkg::FU_MEM;
			end else if (br_req_i[i] && avail[dispatch_pkg::FU_BR]) begin
				hit    = 1'b1;
				hit_fu = dispatch_pkg::FU_BR;
			end

			// fill slot 0 first so it always carries the lower index
			if (hit && cand_vec_i[i] && !pick_v[1]) begin
				avail[hit_fu] = 1'b0;
				if (!pick_v[0]) begin
					pick_v[0] = 1'b1;
					pick_idx0 = dispatch_pkg::ROB_IDX_W'(i);
					pick_fu0  = hit_fu;
				end else begin
					pick_v[1] = 1'b1;
					pick_idx1 = dispatch_pkg::ROB_IDX_W'(i);
					pick_fu1  = hit_fu;
				end
			end
		end
	end

	// ============================================================
	// dispatch slot register
	// ============================================================

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			disp_v_o    <= '0;
			disp_idx0_o <= '0;
			disp_idx1_o <= '0;
			disp_fu0_o  <= dispatch_pkg::FU_ALU0;
			disp_fu1_o  <= dispatch_pkg::FU_ALU0;
		end else begin
			disp_v_o    <= pick_v;
			disp_idx0_o <= pick_idx0;
			disp_idx1_o <= pick_idx1;
			disp_fu0_o  <= pick_fu0;
			disp_fu1_o  <= pick_fu1;
		end
	end

endmodule

`default_nettype wire

//--- design/dispatch_top.sv
// dispatch_top: dispatch stage top, ROB table, ready scan, unit tracker, selector
`timescale 1ns/1ps
`default_nettype none

module dispatch_top (
	input  wire                                     clk,
	input  wire                                     arst_n_i,
	input  wire                                     alloc_v_i,
	input  wire dispatch_pkg::op_class_e            alloc_class_i,
	input  wire [1:0]                               alloc_src_rdy_i,
	output logic [dispatch_pkg::ROB_IDX_W-1:0]      alloc_idx_o,
	output logic                                    rob_full_o,
	input  wire                                     wake_v_i,
	input  wire [dispatch_pkg::ROB_IDX_W-1:0]       wake_idx_i,
	input  wire                                     wake_src_i,
	input  wire [dispatch_pkg::NUM_FU-1:0]          fu_done_i,
	output logic [dispatch_pkg::DISP_WIDTH-1:0]     disp_v_o,
	output logic [dispatch_pkg::ROB_IDX_W-1:0]      disp_idx0_o,
	output logic [dispatch_pkg::ROB_IDX_W-1:0]      disp_idx1_o,
	output dispatch_pkg::fu_id_e                    disp_fu0_o,
	output dispatch_pkg::fu_id_e                    disp_fu1_o
);

	// rob state toward the scan
	logic [dispatch_pkg::ROB_ENTRIES-1:0]                        entry_v;
	logic [dispatch_pkg::ROB_ENTRIES-1:0]                        entry_out;
	logic [dispatch_pkg::ROB_ENTRIES-1:0][1:0]                   entry_src_rdy;
	dispatch_pkg::op_class_e [dispatch_pkg::ROB_ENTRIES-1:0]     entry_class;

	// scan results toward the selector
	logic [dispatch_pkg::ROB_ENTRIES-1:0] cand_vec;
	logic [dispatch_pkg::ROB_ENTRIES-1:0] alu_req;
	logic [dispatch_pkg::ROB_ENTRIES-1:0] mul_req;
	logic [dispatch_pkg::ROB_ENTRIES-1:0] mem_req;
	logic [dispatch_pkg::ROB_ENTRIES-1:0] br_req;

	// unit state
	logic [dispatch_pkg::NUM_FU-1:0]      fu_busy;
	logic [dispatch_pkg::ROB_ENTRIES-1:0] cpl_vec;

	// ============================================================
	// blocks
	// ============================================================

	rob_table u_rob_table (
		.clk             (clk),
		.arst_n_i        (arst_n_i),
		.alloc_v_i       (alloc_v_i),
		.alloc_class_i   (alloc_class_i),
		.alloc_src_rdy_i (alloc_src_rdy_i),
		.wake_v_i        (wake_v_i),
		.wake_idx_i      (wake_idx_i),
		.wake_src_i      (wake_src_i),
		.disp_v_i        (disp_v_o),
		.disp_idx0_i     (disp_idx0_o),
		.disp_idx1_i     (disp_idx1_o),
		.cpl_vec_i       (cpl_vec),
		.alloc_idx_o     (alloc_idx_o),
		.rob_full_o      (rob_full_o),
		.entry_v_o       (entry_v),
		.entry_out_o     (entry_out),
		.entry_src_rdy_o (entry_src_rdy),
		.entry_class_o   (entry_class)
	);

	entry_ready_scan u_entry_ready_scan (
		.entry_v_i       (entry_v),
		.entry_out_i     (entry_out),
		.entry_src_rdy_i (entry_src_rdy),
		.entry_class_i   (entry_class),
		.cand_vec_o      (cand_vec),
		.alu_req_o       (alu_req),
		.mul_req_o       (mul_req),
		.mem_req_o       (mem_req),
		.br_req_o        (br_req)
	);

	// slots double as claim strobes here
	fu_tracker u_fu_tracker (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.disp_v_i    (disp_v_o),
		.disp_idx0_i (disp_idx0_o),
		.disp_idx1_i (disp_idx1_o),
		.disp_fu0_i  (disp_fu0_o),
		.disp_fu1_i  (disp_fu1_o),
		.fu_done_i   (fu_done_i),
		.fu_busy_o   (fu_busy),
		.cpl_vec_o   (cpl_vec)
	);

	dispatch_select u_dispatch_select (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.alu_req_i   (alu_req),
		.mul_req_i   (mul_req),
		.mem_req_i   (mem_req),
		.br_req_i    (br_req),
		.cand_vec_i  (cand_vec),
		.fu_busy_i   (fu_busy),
		.disp_v_o    (disp_v_o),
		.disp_idx0_o (disp_idx0_o),
		.disp_idx1_o (disp_idx1_o),
		.disp_fu0_o  (disp_fu0_o),
		.disp_fu1_o  (disp_fu1_o)
	);

endmodule

`default_nettype wire

//--- verif/tb_dispatch.sv
// tb_dispatch: clock, reset, directed and random stimulus, reference model, checks, timeout
`timescale 1ns/1ps
`default_nettype none

module tb_dispatch;

	localparam int RESET_CYCLES    = 4;
	localparam int DIRECTED_CYCLES = 30;
	localparam int RANDOM_CYCLES   = 400;
	// all tests plus slack
	localparam int CYCLE_LIMIT     = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 100;

	logic                                   clk = 1'b0;
	logic                                   arst_n_i;
	logic                                   alloc_v_i;
	dispatch_pkg::op_class_e                alloc_class_i;
	logic [1:0]                             alloc_src_rdy_i;
	logic [dispatch_pkg::ROB_IDX_W-1:0]     alloc_idx_o;
	logic                                   rob_full_o;
	logic                                   wake_v_i;
	logic [dispatch_pkg::ROB_IDX_W-1:0]     wake_idx_i;
	logic                                   wake_src_i;
	logic [dispatch_pkg::NUM_FU-1:0]        fu_done_i;
	logic [dispatch_pkg::DISP_WIDTH-1:0]    disp_v_o;
	logic [dispatch_pkg::ROB_IDX_W-1:0]     disp_idx0_o;
	logic [dispatch_pkg::ROB_IDX_W-1:0]     disp_idx1_o;
	dispatch_pkg::fu_id_e                   disp_fu0_o;
	dispatch_pkg::fu_id_e                   disp_fu1_o;

	// reference model state, as visible right after an edge
	logic [dispatch_pkg::ROB_ENTRIES-1:0]   m_v;
	logic [dispatch_pkg::ROB_ENTRIES-1:0]   m_out;
	logic [1:0]                             m_rdy [dispatch_pkg::ROB_ENTRIES];
	dispatch_pkg::op_class_e                m_cls [dispatch_pkg::ROB_ENTRIES];
	logic [dispatch_pkg::NUM_FU-1:0]        m_busy;
	logic [dispatch_pkg::ROB_IDX_W-1:0]     m_held [dispatch_pkg::NUM_FU];

	// expected dispatch slots
	logic [1:0]                             exp_v;
	logic [dispatch_pkg::ROB_IDX_W-1:0]     exp_idx [2];
	logic [2:0]                             exp_fu [2];

	integer      seed;
	logic [31:0] rnd;
	int          cycles = 0;
	int          err_count = 0;
	int          check_count = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          test_start_errs = 0;

	dispatch_top dut (
		.clk             (clk),
		.arst_n_i        (arst_n_i),
		.alloc_v_i       (alloc_v_i),
		.alloc_class_i   (alloc_class_i),
		.alloc_src_rdy_i (alloc_src_rdy_i),
		.alloc_idx_o     (alloc_idx_o),
		.rob_full_o      (rob_full_o),
		.wake_v_i        (wake_v_i),
		.wake_idx_i      (wake_idx_i),
		.wake_src_i      (wake_src_i),
		.fu_done_i       (fu_done_i),
		.disp_v_o        (disp_v_o),
		.disp_idx0_o     (disp_idx0_o),
		.disp_idx1_o     (disp_idx1_o),
		.disp_fu0_o      (disp_fu0_o),
		.disp_fu1_o      (disp_fu1_o)
	);

	always #50 clk = ~clk;

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Result: FAILED");
			$finish;
		end
	end

	// ============================================================
	// checking
	// ============================================================

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			$display("** Error: %s = 0x%0h, expected 0x%0h at cycle %0d", name, got, exp, cycles);
			err_count++;
		end
	endtask

	task automatic report_test(input string name);
		int e;
		e = err_count - test_start_errs;
		tests_run++;
		if (e != 0)
			tests_failed++;
		$display("test %s: %s, %0d errors", name, (e == 0) ? "ok" : "failed", e);
		test_start_errs = err_count;
	endtask

	// ============================================================
	// reference model
	// ============================================================

	function automatic logic [2:0] lowest_free();
		logic [2:0] idx;
		logic       found;
		idx   = '0;
		found = 1'b0;
		for (int i = 0; i < dispatch_pkg::ROB_ENTRIES; i++) begin
			if (!found && !m_v[i]) begin
				idx   = 3'(i);
				found = 1'b1;
			end
		end
		return idx;
	endfunction

	// unit a class may take from the free set, -1 when none
	function automatic int pick_unit(input dispatch_pkg::op_class_e cls, input logic [4:0] avail);
		int unit;
		unit = -1;
		case (cls)
			dispatch_pkg::OPC_ALU: begin
				if (avail[0])
					unit = 0;
				else if (avail[1])
					unit = 1;
			end
			dispatch_pkg::OPC_MUL: if (avail[2]) unit = 2;
			dispatch_pkg::OPC_MEM: if (avail[3]) unit = 3;
			default:               if (avail[4]) unit = 4;
		endcase
		return unit;
	endfunction

	// one clock edge, inputs as they were before the edge
	task automatic model_edge();
		logic [4:0] avail;
		logic [2:0] a_idx;
		logic       go;
		int         n;
		int         unit;
		a_idx      = lowest_free();
		go         = alloc_v_i && !(&m_v);
		exp_v      = '0;
		exp_idx[0] = '0;
		exp_idx[1] = '0;
		exp_fu[0]  = '0;
		exp_fu[1]  = '0;
		avail      = ~m_busy;
		n          = 0;
		// in-order pick on the state before the edge, two at most
		for (int i = 0; i < dispatch_pkg::ROB_ENTRIES; i++) begin
			if (n < 2 && m_v[i] && !m_out[i] && m_rdy[i] == 2'b11) begin
				unit = pick_unit(m_cls[i], avail);
				if (unit >= 0) begin
					avail[unit] = 1'b0;
					exp_v[n]    = 1'b1;
					exp_idx[n]  = 3'(i);
					exp_fu[n]   = 3'(unit);
					n++;
				end
			end
		end
		if (wake_v_i && m_v[wake_idx_i])
			m_rdy[wake_idx_i][wake_src_i] = 1'b1;
		// done frees the unit and the entry it held
		for (int f = 0; f < dispatch_pkg::NUM_FU; f++) begin
			if (fu_done_i[f]) begin
				m_v[m_held[f]] = 1'b0;
				m_busy[f]      = 1'b0;
			end
		end
		if (go) begin
			m_v[a_idx]   = 1'b1;
			m_out[a_idx] = 1'b0;
			m_rdy[a_idx] = alloc_src_rdy_i;
			m_cls[a_idx] = alloc_class_i;
		end
		// picks are out and their units busy from this edge
		for (int s = 0; s < 2; s++) begin
			if (exp_v[s]) begin
				m_out[exp_idx[s]] = 1'b1;
				m_busy[exp_fu[s]] = 1'b1;
				m_held[exp_fu[s]] = exp_idx[s];
			end
		end
	endtask

	task automatic compare_outputs();
		check("disp_v_o", 32'(disp_v_o), 32'(exp_v));
		if (exp_v[0]) begin
			check("disp_idx0_o", 32'(disp_idx0_o), 32'(exp_idx[0]));
			check("disp_fu0_o", 32'(disp_fu0_o), 32'(exp_fu[0]));
		end
		if (exp_v[1]) begin
			check("disp_idx1_o", 32'(disp_idx1_o), 32'(exp_idx[1]));
			check("disp_fu1_o", 32'(disp_fu1_o), 32'(exp_fu[1]));
		end
		check("alloc_idx_o", 32'(alloc_idx_o), 32'(lowest_free()));
		check("rob_full_o", 32'(rob_full_o), 32'(&m_v));
	endtask

	// ============================================================
	// stimulus
	// ============================================================

	// values set here are seen by the following edge
	task automatic drive(input logic a_v, input dispatch_pkg::op_class_e a_cls,
		input logic [1:0] a_rdy, input logic w_v, input logic [2:0] w_idx,
		input logic w_src, input logic [4:0] done);
		@(posedge clk);
		model_edge();
		alloc_v_i       <= a_v;
		alloc_class_i   <= a_cls;
		alloc_src_rdy_i <= a_rdy;
		wake_v_i        <= w_v;
		wake_idx_i      <= w_idx;
		wake_src_i      <= w_src;
		// done pulses only on units busy after this edge
		fu_done_i       <= done & m_busy;
		@(negedge clk);
		compare_outputs();
	endtask

	task automatic idle_cycle(input logic [4:0] done);
		drive(1'b0, dispatch_pkg::OPC_ALU, 2'b00, 1'b0, 3'd0, 1'b0, done);
	endtask

	initial begin
		seed            = 32'h3a02e645;
		arst_n_i        = 1'b0;
		alloc_v_i       = 1'b0;
		alloc_class_i   = dispatch_pkg::OPC_ALU;
		alloc_src_rdy_i = 2'b00;
		wake_v_i        = 1'b0;
		wake_idx_i      = '0;
		wake_src_i      = 1'b0;
		fu_done_i       = '0;
		m_v             = '0;
		m_out           = '0;
		m_busy          = '0;
		for (int i = 0; i < dispatch_pkg::ROB_ENTRIES; i++) begin
			m_rdy[i] = 2'b00;
			m_cls[i] = dispatch_pkg::OPC_ALU;
		end
		for (int f = 0; f < dispatch_pkg::NUM_FU; f++)
			m_held[f] = '0;

		repeat (RESET_CYCLES) @(posedge clk);
		arst_n_i <= 1'b1;
		@(negedge clk);

		// empty stage after reset
		check("disp_v_o", 32'(disp_v_o), 32'd0);
		check("rob_full_o", 32'(rob_full_o), 32'd0);
		check("alloc_idx_o", 32'(alloc_idx_o), 32'd0);
		report_test("reset");

		// idx0 waits on src1, idx1 ready, wake idx0 on the same edge as alloc idx1
		drive(1'b1, dispatch_pkg::OPC_ALU, 2'b01, 1'b0, 3'd0, 1'b0, 5'b0);
		drive(1'b1, dispatch_pkg::OPC_ALU, 2'b11, 1'b1, 3'd0, 1'b1, 5'b0);
		idle_cycle(5'b0);
		idle_cycle(5'b0);
		check("disp_v_o", 32'(disp_v_o), 32'b11);
		check("disp_idx0_o", 32'(disp_idx0_o), 32'd0);
		check("disp_idx1_o", 32'(disp_idx1_o), 32'd1);
		check("disp_fu0_o", 32'(disp_fu0_o), 32'(dispatch_pkg::FU_ALU0));
		check("disp_fu1_o", 32'(disp_fu1_o), 32'(dispatch_pkg::FU_ALU1));
		report_test("two_slot_dispatch");

		// third ALU op blocked until alu0 completes
		drive(1'b1, dispatch_pkg::OPC_ALU, 2'b11, 1'b0, 3'd0, 1'b0, 5'b0);
		idle_cycle(5'b0);
		idle_cycle(5'b00001);
		check("disp_v_o", 32'(disp_v_o), 32'd0);
		idle_cycle(5'b0);
		check("disp_v_o", 32'(disp_v_o), 32'd0);
		check("alloc_idx_o", 32'(alloc_idx_o), 32'd0);
		idle_cycle(5'b0);
		check("disp_v_o", 32'(disp_v_o), 32'b01);
		check("disp_idx0_o", 32'(disp_idx0_o), 32'd2);
		check("disp_fu0_o", 32'(disp_fu0_o), 32'(dispatch_pkg::FU_ALU0));
		// drain both alus
		idle_cycle(5'b00011);
		idle_cycle(5'b0);
		report_test("busy_unit");

		// fill with unready entries, classes cycle through all four
		for (int i = 0; i < dispatch_pkg::ROB_ENTRIES; i++) begin
			drive(1'b1, dispatch_pkg::op_class_e'(i[1:0]), 2'b00, 1'b0, 3'd0, 1'b0, 5'b0);
			check("alloc_idx_o", 32'(alloc_idx_o), 32'(i));
			check("rob_full_o", 32'(rob_full_o), 32'd0);
		end
		idle_cycle(5'b0);
		check("rob_full_o", 32'(rob_full_o), 32'd1);
		report_test("rob_fill");

		// entry 0 becomes ready one source at a time
		drive(1'b0, dispatch_pkg::OPC_ALU, 2'b00, 1'b1, 3'd0, 1'b0, 5'b0);
		drive(1'b0, dispatch_pkg::OPC_ALU, 2'b00, 1'b1, 3'd0, 1'b1, 5'b0);
		idle_cycle(5'b0);
		check("disp_v_o", 32'(disp_v_o), 32'd0);
		idle_cycle(5'b0);
		check("disp_v_o", 32'(disp_v_o), 32'b01);
		check("disp_idx0_o", 32'(disp_idx0_o), 32'd0);
		check("disp_fu0_o", 32'(disp_fu0_o), 32'(dispatch_pkg::FU_ALU0));
		report_test("wakeup");

		// random mix, model compared every cycle inside drive
		for (int k = 0; k < RANDOM_CYCLES; k++) begin
			rnd = $random(seed);
			drive(rnd[0], dispatch_pkg::op_class_e'(rnd[2:1]), rnd[4:3], rnd[5] | rnd[6],
				rnd[9:7], rnd[10], rnd[15:11]);
		end
		report_test("random_mix");

		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, check_count, err_count);
		if (err_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
design/dispatch_pkg.sv
design/rob_table.sv
design/entry_ready_scan.sv
design/fu_tracker.sv
design/dispatch_select.sv
design/dispatch_top.sv
verif/tb_dispatch.sv

//--- Makefile
# Verilator build and run for the dispatch stage testbench

VERILATOR ?= verilator
TOP       ?= tb_dispatch
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Result: PASSED
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
